/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tbMipsCore -f filelist.f --Mdir obj_dir -o VtbMipsCore
	./obj_dir/VtbMipsCore > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/execUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module execUnit (
    input  wire pipeCtrlPkg::aluOp_t  aluOp_i,
    input  wire mipsIsaPkg::word_t    srcA_i,
    input  wire mipsIsaPkg::word_t    srcB_i,
    input  wire pipeCtrlPkg::brKind_t brKind_i,
    input  wire mipsIsaPkg::word_t    rsVal_i,
    input  wire mipsIsaPkg::word_t    rtVal_i,
    output mipsIsaPkg::word_t         result_o,
    output logic                      branchTaken_o
);

    logic regsEqual;

    always_comb begin
        case (aluOp_i)
            pipeCtrlPkg::ALU_ADD: result_o = srcA_i + srcB_i;
            pipeCtrlPkg::ALU_SUB: result_o = srcA_i - srcB_i;
            pipeCtrlPkg::ALU_AND: result_o = srcA_i & srcB_i;
            pipeCtrlPkg::ALU_OR:  result_o = srcA_i | srcB_i;
            pipeCtrlPkg::ALU_XOR: result_o = srcA_i ^ srcB_i;
            pipeCtrlPkg::ALU_SLT: begin
                result_o = {31'b0, $signed(srcA_i) < $signed(srcB_i)};
            end
            pipeCtrlPkg::ALU_LUI: begin
                // immediate goes to the upper half
                result_o = {srcB_i[mipsIsaPkg::IMM_W-1:0], {mipsIsaPkg::IMM_W{1'b0}}};
            end
            default:              result_o = '0;
        endcase
    end

    // compare uses forwarded rs/rt
    assign regsEqual = (rsVal_i == rtVal_i);

    always_comb begin
        case (brKind_i)
            pipeCtrlPkg::BR_EQ: branchTaken_o = regsEqual;
            pipeCtrlPkg::BR_NE: branchTaken_o = !regsEqual;
            default:            branchTaken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/hazardIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface hazardIf;

    logic stallF, stallD, freeze;
    logic flushD, flushE;
    pipeCtrlPkg::fwdSel_t fwdA, fwdB;

    mipsIsaPkg::regIdx_t rsD, rtD, rsE, rtE;
    mipsIsaPkg::regIdx_t destE, destM, destW;
    logic regWriteE, regWriteM, regWriteW;
    logic memReadE;
    logic branchTaken, jumpD, dataStall;

    modport hazard (
        output stallF, stallD, freeze, flushD, flushE, fwdA, fwdB,
        input  rsD, rtD, rsE, rtE, destE, destM, destW,
        input  regWriteE, regWriteM, regWriteW, memReadE,
        input  branchTaken, jumpD, dataStall
    );

    modport datapath (
        input  stallF, stallD, freeze, flushD, flushE, fwdA, fwdB,
        output rsD, rtD, rsE, rtE, destE, destM, destW,
        output regWriteE, regWriteM, regWriteW, memReadE,
        output branchTaken, jumpD, dataStall
    );

endinterface

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
    hazardIf.hazard hz
);

    logic loadUse;

    // memory stage wins over writeback, r0 never forwarded
    function automatic pipeCtrlPkg::fwdSel_t pickFwd(
        input mipsIsaPkg::regIdx_t src,
        input logic                wrM,
        input mipsIsaPkg::regIdx_t dstM,
        input logic                wrW,
        input mipsIsaPkg::regIdx_t dstW
    );
        if (src == mipsIsaPkg::REG_ZERO) begin
            return pipeCtrlPkg::FWD_NONE;
        end
        if (wrM && dstM == src) begin
            return pipeCtrlPkg::FWD_MEM;
        end
        if (wrW && dstW == src) begin
            return pipeCtrlPkg::FWD_WB;
        end
        return pipeCtrlPkg::FWD_NONE;
    endfunction

    assign hz.fwdA = pickFwd(hz.rsE, hz.regWriteM, hz.destM, hz.regWriteW, hz.destW);
    assign hz.fwdB = pickFwd(hz.rtE, hz.regWriteM, hz.destM, hz.regWriteW, hz.destW);

    // load in execute, consumer in decode
    assign loadUse = hz.memReadE && hz.regWriteE
                  && hz.destE != mipsIsaPkg::REG_ZERO
                  && (hz.destE == hz.rsD || hz.destE == hz.rtD);

    assign hz.freeze = hz.dataStall;
    assign hz.stallF = loadUse;
    assign hz.stallD = loadUse;

    // a stalled jump must stay in decode until it can redirect
    assign hz.flushD = !hz.freeze && (hz.branchTaken || (hz.jumpD && !loadUse));
    assign hz.flushE = !hz.freeze && (hz.branchTaken || loadUse);

endmodule

`default_nettype wire

/* design/instDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instDecoder (
    input  wire mipsIsaPkg::word_t instr_i,
    output pipeCtrlPkg::aluOp_t    aluOp_o,
    output logic                   useImm_o,
    output logic                   signExt_o,
    output logic                   regWrite_o,
    output logic                   destIsRt_o,
    output logic                   memRead_o,
    output logic                   memWrite_o,
    output pipeCtrlPkg::brKind_t   brKind_o,
    output logic                   jump_o
);

    mipsIsaPkg::opcode_t opcode;
    mipsIsaPkg::funct_t  funct;

    assign opcode = instr_i[mipsIsaPkg::OPC_LSB +: 6];
    assign funct  = instr_i[mipsIsaPkg::FN_LSB +: 6];

    always_comb begin
        // default is a nop
        aluOp_o    = pipeCtrlPkg::ALU_ADD;
        useImm_o   = 1'b0;
        signExt_o  = 1'b0;
        regWrite_o = 1'b0;
        destIsRt_o = 1'b0;
        memRead_o  = 1'b0;
        memWrite_o = 1'b0;
        brKind_o   = pipeCtrlPkg::BR_NONE;
        jump_o     = 1'b0;
        case (opcode)
            mipsIsaPkg::OP_SPECIAL: begin
                regWrite_o = 1'b1;
                case (funct)
                    mipsIsaPkg::FN_ADDU: aluOp_o = pipeCtrlPkg::ALU_ADD;
                    mipsIsaPkg::FN_SUBU: aluOp_o = pipeCtrlPkg::ALU_SUB;
                    mipsIsaPkg::FN_AND:  aluOp_o = pipeCtrlPkg::ALU_AND;
                    mipsIsaPkg::FN_OR:   aluOp_o = pipeCtrlPkg::ALU_OR;
                    mipsIsaPkg::FN_XOR:  aluOp_o = pipeCtrlPkg::ALU_XOR;
                    mipsIsaPkg::FN_SLT:  aluOp_o = pipeCtrlPkg::ALU_SLT;
                    default:             regWrite_o = 1'b0;  // also sll r0 bubble
                endcase
            end
            mipsIsaPkg::OP_ADDIU, mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_LUI: begin
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                destIsRt_o = 1'b1;
                signExt_o  = (opcode == mipsIsaPkg::OP_ADDIU);  // ori is zero extended
                if (opcode == mipsIsaPkg::OP_ORI) begin
                    aluOp_o = pipeCtrlPkg::ALU_OR;
                end else if (opcode == mipsIsaPkg::OP_LUI) begin
                    aluOp_o = pipeCtrlPkg::ALU_LUI;
                end
            end
            mipsIsaPkg::OP_LW: begin
                useImm_o   = 1'b1;
                signExt_o  = 1'b1;
                regWrite_o = 1'b1;
                destIsRt_o = 1'b1;
                memRead_o  = 1'b1;
            end
            mipsIsaPkg::OP_SW: begin
                useImm_o   = 1'b1;
                signExt_o  = 1'b1;
                memWrite_o = 1'b1;
            end
            mipsIsaPkg::OP_BEQ: begin
                signExt_o = 1'b1;
                brKind_o  = pipeCtrlPkg::BR_EQ;
            end
            mipsIsaPkg::OP_BNE: begin
                signExt_o = 1'b1;
                brKind_o  = pipeCtrlPkg::BR_NE;
            end
            mipsIsaPkg::OP_J: jump_o = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
    input  wire                        clk,
    input  wire                        rstN_i,
    // instruction port
    output mipsIsaPkg::word_t          instAddr_o,
    input  wire mipsIsaPkg::word_t     instData_i,
    // data port
    output logic                       memEn_o,
    output mipsIsaPkg::byteMask_t      memWen_o,
    output mipsIsaPkg::word_t          memAddr_o,
    output mipsIsaPkg::word_t          memWdata_o,
    input  wire mipsIsaPkg::word_t     memRdata_i,
    input  wire                        dataStall_i,
    // debug trace
    output mipsIsaPkg::word_t          debugWbPc_o,
    output mipsIsaPkg::byteMask_t      debugWbWen_o,
    output mipsIsaPkg::regIdx_t        debugWbNum_o,
    output mipsIsaPkg::word_t          debugWbData_o
);

    hazardIf hzd ();

    mipsIsaPkg::word_t pcF, pcNext;
    // decode
    mipsIsaPkg::word_t instrD, pcD, pcPlus4D, immD, jumpTargetD, rdValAD, rdValBD;
    mipsIsaPkg::regIdx_t destD;
    pipeCtrlPkg::aluOp_t aluOpD;
    pipeCtrlPkg::brKind_t brKindD;
    logic useImmD, signExtD, regWriteD, destIsRtD, memReadD, memWriteD, jumpD;
    // execute
    mipsIsaPkg::word_t pcE, rdValAE, rdValBE, immE, rsFwdE, rtFwdE, srcBE;
    mipsIsaPkg::word_t aluOutE, branchTargetE;
    mipsIsaPkg::regIdx_t rsE, rtE, destE;
    pipeCtrlPkg::aluOp_t aluOpE;
    pipeCtrlPkg::brKind_t brKindE;
    pipeCtrlPkg::resSel_t resSelE;
    logic useImmE, regWriteE, memReadE, memWriteE, branchTakenE;
    // memory
    mipsIsaPkg::word_t pcM, aluOutM, rtValM, resultM;
    mipsIsaPkg::regIdx_t destM;
    pipeCtrlPkg::resSel_t resSelM;
    logic regWriteM, memReadM, memWriteM;
    // writeback, only kept for forwarding
    mipsIsaPkg::word_t resultW;
    mipsIsaPkg::regIdx_t destW;
    logic regWriteW;

    assign instAddr_o = pcF;
    assign pcNext = branchTakenE ? branchTargetE :
                    jumpD        ? jumpTargetD   : pcF + 32'd4;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF <= pipeCtrlPkg::RESET_PC;
        end else if (!hzd.freeze && !hzd.stallF) begin
            pcF <= pcNext;
        end
    end

    // F/D, a flushed word becomes sll r0 which decodes as a nop
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            instrD <= '0;
        end else if (!hzd.freeze) begin
            if (hzd.flushD) begin
                instrD <= '0;
            end else if (!hzd.stallD) begin
                instrD <= instData_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hzd.freeze && !hzd.stallD) begin
            pcD <= pcF;
        end
    end

    instDecoder i_instDecoder (
        .instr_i   (instrD),
        .aluOp_o   (aluOpD),
        .useImm_o  (useImmD),
        .signExt_o (signExtD),
        .regWrite_o(regWriteD),
        .destIsRt_o(destIsRtD),
        .memRead_o (memReadD),
        .memWrite_o(memWriteD),
        .brKind_o  (brKindD),
        .jump_o    (jumpD)
    );

    regFile i_regFile (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .we_i    (regWriteM && !hzd.freeze),  // written at end of memory stage
        .wAddr_i (destM),
        .wData_i (resultM),
        .rAddrA_i(hzd.rsD),
        .rAddrB_i(hzd.rtD),
        .rDataA_o(rdValAD),
        .rDataB_o(rdValBD)
    );

    assign hzd.rsD = instrD[mipsIsaPkg::RS_LSB +: 5];
    assign hzd.rtD = instrD[mipsIsaPkg::RT_LSB +: 5];
    assign destD = destIsRtD ? hzd.rtD : instrD[mipsIsaPkg::RD_LSB +: 5];
    assign immD = signExtD ? {{16{instrD[15]}}, instrD[mipsIsaPkg::IMM_W-1:0]}
                           : {16'b0, instrD[mipsIsaPkg::IMM_W-1:0]};
    assign pcPlus4D = pcD + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], instrD[mipsIsaPkg::TGT_W-1:0], 2'b00};

    // D/E
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            brKindE   <= pipeCtrlPkg::BR_NONE;
        end else if (!hzd.freeze) begin
            regWriteE <= regWriteD && !hzd.flushE;
            memReadE  <= memReadD && !hzd.flushE;
            memWriteE <= memWriteD && !hzd.flushE;
            brKindE   <= hzd.flushE ? pipeCtrlPkg::BR_NONE : brKindD;
        end
    end

    always_ff @(posedge clk) begin
        if (!hzd.freeze) begin
            pcE     <= pcD;
            rsE     <= hzd.rsD;
            rtE     <= hzd.rtD;
            destE   <= destD;
            rdValAE <= rdValAD;
            rdValBE <= rdValBD;
            immE    <= immD;
            aluOpE  <= aluOpD;
            useImmE <= useImmD;
            resSelE <= memReadD ? pipeCtrlPkg::RES_MEM : pipeCtrlPkg::RES_ALU;
        end
    end

    assign rsFwdE = (hzd.fwdA == pipeCtrlPkg::FWD_MEM) ? resultM :
                    (hzd.fwdA == pipeCtrlPkg::FWD_WB)  ? resultW : rdValAE;
    assign rtFwdE = (hzd.fwdB == pipeCtrlPkg::FWD_MEM) ? resultM :
                    (hzd.fwdB == pipeCtrlPkg::FWD_WB)  ? resultW : rdValBE;
    assign srcBE = useImmE ? immE : rtFwdE;
    assign branchTargetE = pcE + 32'd4 + {immE[29:0], 2'b00};

    execUnit i_execUnit (
        .aluOp_i      (aluOpE),
        .srcA_i       (rsFwdE),
        .srcB_i       (srcBE),
        .brKind_i     (brKindE),
        .rsVal_i      (rsFwdE),
        .rtVal_i      (rtFwdE),
        .result_o     (aluOutE),
        .branchTaken_o(branchTakenE)
    );

    // E/M
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
        end else if (!hzd.freeze) begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        if (!hzd.freeze) begin
            pcM     <= pcE;
            destM   <= destE;
            aluOutM <= aluOutE;
            rtValM  <= rtFwdE;  // store data
            resSelM <= resSelE;
        end
    end

    assign memEn_o    = memReadM || memWriteM;
    assign memWen_o   = {4{memWriteM}};
    assign memAddr_o  = aluOutM;
    assign memWdata_o = rtValM;
    assign resultM    = (resSelM == pipeCtrlPkg::RES_MEM) ? memRdata_i : aluOutM;

    // M/W
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteW <= 1'b0;
        end else if (!hzd.freeze) begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        if (!hzd.freeze) begin
            destW   <= destM;
            resultW <= resultM;
        end
    end

    assign hzd.rsE         = rsE;
    assign hzd.rtE         = rtE;
    assign hzd.destE       = destE;
    assign hzd.destM       = destM;
    assign hzd.destW       = destW;
    assign hzd.regWriteE   = regWriteE;
    assign hzd.regWriteM   = regWriteM;
    assign hzd.regWriteW   = regWriteW;
    assign hzd.memReadE    = memReadE;
    assign hzd.branchTaken = branchTakenE;
    assign hzd.jumpD       = jumpD;
    assign hzd.dataStall   = dataStall_i;

    hazardUnit i_hazardUnit (
        .hz(hzd.hazard)
    );

    assign debugWbPc_o   = pcM;
    assign debugWbWen_o  = {4{regWriteM && !hzd.freeze}};
    assign debugWbNum_o  = destM;
    assign debugWbData_o = resultM;

endmodule

`default_nettype wire

/* design/mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

    typedef logic [31:0] word_t;      // data word, address or instruction
    typedef logic [4:0]  regIdx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  byteMask_t;

    localparam regIdx_t REG_ZERO = 5'd0;

    // instruction field positions
    localparam int OPC_LSB = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int FN_LSB  = 0;
    localparam int IMM_W   = 16;
    localparam int TGT_W   = 26;

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0D;
    localparam opcode_t OP_LUI     = 6'h0F;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2B;

    // SPECIAL function codes
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2A;

endpackage

`default_nettype wire

/* design/pipeCtrlPkg.sv */
`default_nettype none

package pipeCtrlPkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

    // operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwdSel_t;

    typedef enum logic {
        RES_ALU,
        RES_MEM
    } resSel_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } brKind_t;

    localparam mipsIsaPkg::word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire                      clk,
    input  wire                      rstN_i,
    input  wire                      we_i,
    input  wire mipsIsaPkg::regIdx_t wAddr_i,
    input  wire mipsIsaPkg::word_t   wData_i,
    input  wire mipsIsaPkg::regIdx_t rAddrA_i,
    input  wire mipsIsaPkg::regIdx_t rAddrB_i,
    output mipsIsaPkg::word_t        rDataA_o,
    output mipsIsaPkg::word_t        rDataB_o
);

    mipsIsaPkg::word_t regs [1:31];  // r0 is not stored

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wAddr_i != mipsIsaPkg::REG_ZERO) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    function automatic mipsIsaPkg::word_t readPort(input mipsIsaPkg::regIdx_t addr);
        if (addr == mipsIsaPkg::REG_ZERO) begin
            return '0;
        end
        if (we_i && addr == wAddr_i) begin
            return wData_i;  // write-through
        end
        return regs[addr];
    endfunction

    assign rDataA_o = readPort(rAddrA_i);
    assign rDataB_o = readPort(rAddrB_i);

endmodule

`default_nettype wire

/* filelist.f */
design/mipsIsaPkg.sv
design/pipeCtrlPkg.sv
design/hazardIf.sv
design/instDecoder.sv
design/regFile.sv
design/execUnit.sv
design/hazardUnit.sv
design/mipsCore.sv
sim/tbClockGen.sv
sim/tbMipsCore.sv

/* sim/mipsStimulus.txt */
# I addr instr | W pc reg(dec) data | S addr data | T test number
# all values hex unless noted
I 00000000 3C011234
I 00000004 34215678
I 00000008 2402FFFB
I 0000000C 00221821
I 00000010 00612023
I 00000014 0080282A
I 00000018 00233024
I 0000001C 00C53826
I 00000020 00E44025
I 00000024 24090040
I 00000028 AD210000
I 0000002C AD230004
I 00000030 8D2A0000
I 00000034 014A5821
I 00000038 8D2C0004
I 0000003C AD2C0008
I 00000040 8D2D0008
I 00000044 01A37023
I 00000048 11C00001
I 0000004C 240F0BAD
I 00000050 15C00001
I 00000054 24100007
I 00000058 16000002
I 0000005C AC100000
I 00000060 240F0BAD
I 00000064 12000001
I 00000068 0800001D
I 0000006C 240F0BAD
I 00000070 AC100000
I 00000074 26110001
I 00000078 AD31000C
I 0000007C 0800001F
T 2
W 00000000 1 12340000
W 00000004 1 12345678
W 00000008 2 FFFFFFFB
W 0000000C 3 12345673
W 00000010 4 FFFFFFFB
W 00000014 5 00000001
W 00000018 6 12345670
W 0000001C 7 12345671
W 00000020 8 FFFFFFFB
T 3
W 00000024 9 00000040
S 00000040 12345678
S 00000044 12345673
W 00000030 10 12345678
W 00000034 11 2468ACF0
W 00000038 12 12345673
S 00000048 12345673
W 00000040 13 12345673
W 00000044 14 00000000
T 4
W 00000054 16 00000007
W 00000074 17 00000008
S 0000004C 00000008

/* sim/tbClockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module tbClockGen (
    output logic clk_o,
    output logic rstN_o
);

    localparam int HALF_PERIOD_NS = 50;  // 100 ns clock
    localparam int RESET_CYCLES   = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD_NS clk_o = ~clk_o;
    end

    initial begin
        rstN_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstN_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tbMipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module tbMipsCore;

    localparam int MEM_WORDS = 256;
    localparam int CLK_NS    = 100;
    localparam int NUM_TESTS = 4;

    logic        clk, rstN;
    logic [31:0] instAddr, instData, memAddr, memWdata, memRdata;
    logic [31:0] dbgPc, dbgData;
    logic [3:0]  memWen, dbgWen;
    logic [4:0]  dbgNum;
    logic        memEn, dataStall;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];

    // expected trace, in retirement order
    logic [31:0] expWPc[$];
    logic [31:0] expWData[$];
    logic [4:0]  expWReg[$];
    int          expWTest[$];
    logic [31:0] expSAddr[$];
    logic [31:0] expSData[$];
    int          expSTest[$];

    int wEnd [1:NUM_TESTS];
    int sEnd [1:NUM_TESTS];
    int wIdx = 0;
    int sIdx = 0;
    int errorCount = 0;
    int testsFailed = 0;
    bit loaded = 1'b0;

    tbClockGen i_clkGen (
        .clk_o (clk),
        .rstN_o(rstN)
    );

    mipsCore i_dut (
        .clk          (clk),
        .rstN_i       (rstN),
        .instAddr_o   (instAddr),
        .instData_i   (instData),
        .memEn_o      (memEn),
        .memWen_o     (memWen),
        .memAddr_o    (memAddr),
        .memWdata_o   (memWdata),
        .memRdata_i   (memRdata),
        .dataStall_i  (dataStall),
        .debugWbPc_o  (dbgPc),
        .debugWbWen_o (dbgWen),
        .debugWbNum_o (dbgNum),
        .debugWbData_o(dbgData)
    );

    // both memories answer in the same cycle
    assign instData = imem[instAddr[9:2]];
    assign memRdata = dmem[memAddr[9:2]];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic loadStimulus();
        int fd;
        int n;
        int testNo;
        int regNo;
        string line;
        logic [31:0] a;
        logic [31:0] b;
        testNo = 1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        fd = $fopen("sim/mipsStimulus.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open the stimulus file sim/mipsStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n < 2 || line[0] == "#") begin
                    continue;
                end
                case (line[0])
                    "I": begin
                        n = $sscanf(line, "I %h %h", a, b);
                        imem[a[9:2]] = b;
                    end
                    "W": begin
                        n = $sscanf(line, "W %h %d %h", a, regNo, b);
                        expWPc.push_back(a);
                        expWReg.push_back(regNo[4:0]);
                        expWData.push_back(b);
                        expWTest.push_back(testNo);
                    end
                    "S": begin
                        n = $sscanf(line, "S %h %h", a, b);
                        expSAddr.push_back(a);
                        expSData.push_back(b);
                        expSTest.push_back(testNo);
                    end
                    "T": n = $sscanf(line, "T %d", testNo);
                    default: ;
                endcase
            end
            $fclose(fd);
        end
        // a test ends once every record up to it has been seen
        for (int t = 1; t <= NUM_TESTS; t++) begin
            wEnd[t] = 0;
            sEnd[t] = 0;
            foreach (expWTest[i]) begin
                if (expWTest[i] <= t) wEnd[t]++;
            end
            foreach (expSTest[i]) begin
                if (expSTest[i] <= t) sEnd[t]++;
            end
        end
    endtask

    task automatic checkWrite();
        if (wIdx >= expWPc.size()) begin
            errorCount++;
            $display("unexpected register write to r%0d from pc 0x%h", dbgNum, dbgPc);
        end else begin
            checkValue("debugWbPc_o", dbgPc, expWPc[wIdx]);
            checkValue("debugWbNum_o", {27'b0, dbgNum}, {27'b0, expWReg[wIdx]});
            checkValue("debugWbData_o", dbgData, expWData[wIdx]);
            wIdx++;
        end
    endtask

    task automatic checkStore();
        if (sIdx >= expSAddr.size()) begin
            errorCount++;
            $display("unexpected store to address 0x%h", memAddr);
        end else begin
            checkValue("memAddr_o", memAddr, expSAddr[sIdx]);
            checkValue("memWdata_o", memWdata, expSData[sIdx]);
            sIdx++;
        end
    endtask

    task automatic reportTest(input int t, input string name, input int errBefore);
        int errs;
        string verdict;
        errs = errorCount - errBefore;
        if (errs != 0) begin
            testsFailed++;
            verdict = "FAILED";
        end else begin
            verdict = "ok";
        end
        $display("test %0d %s: %s, %0d errors", t, name, verdict, errs);
    endtask

    // random wait states on the data port
    initial begin : stallDriver
        logic [31:0] rng;
        rng = 32'd70987;
        dataStall <= 1'b0;
        forever begin
            @(posedge clk);
            rng = xorshift32(rng);
            dataStall <= memEn && (rng[1:0] == 2'b00);
        end
    end

    // data memory and trace monitor, sampled at the edge
    initial begin : traceMonitor
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] <= '0;
        end
        forever begin
            @(posedge clk);
            if (rstN) begin
                if (dbgWen == 4'hF) begin
                    checkWrite();
                end
                if (memEn && !dataStall) begin
                    if (memWen == 4'hF) begin
                        checkStore();
                        dmem[memAddr[9:2]] <= memWdata;
                    end else begin
                        checkValue("memWen_o", {28'b0, memWen}, 32'h0);  // loads carry no mask
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int limitNs;
        wait (loaded);
        limitNs = (expWPc.size() + expSAddr.size()) * 20 * CLK_NS;
        #(limitNs);
        $display("timeout after %0d ns, %0d of %0d writes and %0d of %0d stores seen",
                 limitNs, wIdx, expWPc.size(), sIdx, expSAddr.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin : mainSequence
        int errBefore;
        string names [1:NUM_TESTS];
        names[1] = "reset";
        names[2] = "alu and forwarding";
        names[3] = "loads and stores";
        names[4] = "branches and jump";
        loadStimulus();
        loaded = 1'b1;

        errBefore = errorCount;
        // last pass is the first cycle out of reset
        do begin
            @(negedge clk);
            checkValue("memEn_o", {31'b0, memEn}, 32'h0);
            checkValue("debugWbWen_o", {28'b0, dbgWen}, 32'h0);
            checkValue("instAddr_o", instAddr, 32'h0000_0000);
        end while (!rstN);
        reportTest(1, names[1], errBefore);

        for (int t = 2; t <= NUM_TESTS; t++) begin
            errBefore = errorCount;
            wait (wIdx >= wEnd[t] && sIdx >= sEnd[t]);
            reportTest(t, names[t], errBefore);
        end

        repeat (20) @(posedge clk);  // catch stray writes after the trace
        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
